//--- sources.f
rtl/fb_pkg.sv
rtl/sync_generator.sv
rtl/vga_ram.sv
rtl/frame_buffer.sv
rtl/video_output.sv
rtl/hack_vga_top.sv
test/tb_clock.sv
test/hack_vga_asserts.sv
test/tb_hack_vga.sv

//--- Makefile
# Verilator build for the Hack VGA display testbench

VERILATOR ?= verilator
TOP       ?= tb_hack_vga
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SOURCES   := $(shell cat $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_hack_vga.sv
`timescale 1ns/100ps
`default_nettype none

module tb_hack_vga import fb_pkg::*; ();

    localparam int H_ACTIVE = 800;
    localparam int H_FRONT  = 40;
    localparam int H_SYNC   = 128;
    localparam int H_BACK   = 88;
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 3;
    localparam int V_BACK   = 21;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;   // 1056
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;   // 505
    localparam int WORDS     = 1 << ADDR_BITS;                        // 8192 screen words
    localparam int ROW_WORDS = SCREEN_W / WORD_BITS;                  // 32 words per line
    localparam int WRITE_SKIP = 4;                   // recent writes may not be visible yet
    localparam int TIMEOUT_CYCLES = WORDS + 3 * H_TOTAL * V_TOTAL;    // fill plus three frames

    logic                 clk;
    logic                 rst_n;
    logic [ADDR_BITS-1:0] write_address;
    logic [WORD_BITS-1:0] data_in;
    logic                 load;
    logic                 hsync;
    logic                 vsync;
    logic                 active;
    logic                 pixel_out;

    logic [WORD_BITS-1:0] model_mem [WORDS];         // mirror of every write
    int                   last_write [WORDS];        // cycle of the latest write per word
    bit                   rewritten [WORDS];         // rewritten while frames are checked
    integer               seed;
    int                   cycle;                     // negedge count of the main loop
    int                   clk_count;                 // posedge count for the timeout
    int                   mh;                        // model raster column
    int                   mv;                        // model raster line
    int                   frames_done;
    int                   rewrite_hits;              // rewritten words seen with new value
    bit                   locked;                    // model follows the raster
    bit                   vsync_seen;
    logic                 prev_active;

    tb_clock #(.PERIOD(4), .RESET_CYCLES(8)) u_clock (.clk(clk), .rst_n(rst_n));

    hack_vga_top #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_address(write_address),
        .data_in      (data_in),
        .load         (load),
        .hsync        (hsync),
        .vsync        (vsync),
        .active       (active),
        .pixel_out    (pixel_out)
    );

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        assert (actual === expected) else begin
            $display("[FAIL] t=%0t %s expected %0b actual %0b", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic write_word(logic [ADDR_BITS-1:0] addr, logic [WORD_BITS-1:0] data);
        write_address   = addr;
        data_in         = data;
        load            = 1'b1;                      // stored at the next rising edge
        model_mem[addr] = data;
        last_write[addr] = cycle;
        rewritten[addr] = locked;                    // only rewrites during display count
    endtask

    task automatic idle_writer();
        load = 1'b0;
    endtask

    // sample at the falling edge, outputs settled since the rising edge
    task automatic observe_outputs();
        int addr;
        cycle++;
        if (!vsync) vsync_seen = 1'b1;
        if (!locked && vsync_seen && !prev_active && active) begin
            locked = 1'b1;                           // first line of a full frame
            mh     = 0;
            mv     = 0;
        end
        if (locked) begin
            check_bit("active", (mh < H_ACTIVE) && (mv < V_ACTIVE), active);
            check_bit("hsync", !((mh >= H_ACTIVE + H_FRONT) &&
                                 (mh <  H_ACTIVE + H_FRONT + H_SYNC)), hsync);
            check_bit("vsync", !((mv >= V_ACTIVE + V_FRONT) &&
                                 (mv <  V_ACTIVE + V_FRONT + V_SYNC)), vsync);
            if ((mh < SCREEN_W) && (mv < SCREEN_H)) begin
                addr = mv * ROW_WORDS + mh / WORD_BITS;
                if (cycle - last_write[addr] >= WRITE_SKIP) begin
                    check_bit("pixel_out", model_mem[addr][mh % WORD_BITS], pixel_out);
                    if (rewritten[addr]) begin
                        rewrite_hits++;              // new word reached the screen
                        rewritten[addr] = 1'b0;
                    end
                end
            end else begin
                check_bit("pixel_out", 1'b0, pixel_out);   // border stays black
            end
            mh++;
            if (mh == H_TOTAL) begin
                mh = 0;
                mv++;
                if (mv == V_TOTAL) begin
                    mv = 0;
                    frames_done++;
                end
            end
        end
        prev_active = active;
    endtask

    always @(posedge clk) begin
        clk_count = clk_count + 1;
        if (clk_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    initial begin
        seed          = 32'h3336b862;
        write_address = '0;
        data_in       = '0;
        load          = 1'b0;
        cycle         = 0;
        clk_count     = 0;
        mh            = 0;
        mv            = 0;
        frames_done   = 0;
        rewrite_hits  = 0;
        locked        = 1'b0;
        vsync_seen    = 1'b0;
        prev_active   = 1'b0;
        for (int a = 0; a < WORDS; a++) begin
            model_mem[a]  = '0;
            last_write[a] = -WRITE_SKIP;
            rewritten[a]  = 1'b0;
        end

        @(negedge clk);                              // still in reset
        check_bit("hsync", 1'b1, hsync);
        check_bit("vsync", 1'b1, vsync);
        check_bit("active", 1'b0, active);
        check_bit("pixel_out", 1'b0, pixel_out);
        wait (rst_n === 1'b1);

        for (int i = 0; i < WORDS; i++) begin       // fill the whole screen
            @(negedge clk);
            observe_outputs();
            write_word(ADDR_BITS'(i), WORD_BITS'($random(seed)));
        end

        while (frames_done < 2) begin               // two checked frames, writes go on
            @(negedge clk);
            observe_outputs();
            if (($random(seed) & 3) == 0) begin
                write_word(ADDR_BITS'($random(seed)), WORD_BITS'($random(seed)));
            end else begin
                idle_writer();
            end
        end

        @(negedge clk);
        idle_writer();
        if (rewrite_hits > 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("no word rewritten during display was seen with its new value");
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

//--- test/hack_vga_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module hack_vga_asserts #(
    parameter int H_SYNC  = 128,                     // expected hsync pulse width
    parameter int H_TOTAL = 1056                     // expected line length
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic hsync,
    input wire logic active,
    input wire logic pixel,                          // frame buffer pixel before the gate
    input wire logic active_lvl                      // delayed active, level with pixel
);

    int unsigned low_len;                            // length of the current low run of hsync
    int unsigned period;                             // cycles since the last hsync fall
    logic        hsync_q;                            // hsync one cycle ago
    logic        seen_fall;                          // one full period is measurable

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            low_len   <= 0;
            period    <= 0;
            hsync_q   <= 1'b1;
            seen_fall <= 1'b0;
        end else begin
            hsync_q <= hsync;
            low_len <= hsync ? 0 : low_len + 1;      // restart on every high cycle
            if (hsync_q && !hsync) begin
                period    <= 1;                      // falling edge starts a new line
                seen_fall <= 1'b1;
            end else begin
                period <= period + 1;
            end
        end
    end

    a_hsync_width: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(hsync) |-> (low_len == H_SYNC))
        else $error("hsync low pulse width differs from H_SYNC");

    a_hsync_period: assert property (@(posedge clk) disable iff (!rst_n)
        ($fell(hsync) && seen_fall) |-> (period == H_TOTAL))
        else $error("hsync period differs from the line length");

    a_active_in_sync: assert property (@(posedge clk) disable iff (!rst_n)
        !(active && !hsync))
        else $error("active is high during the hsync pulse");

    // pos (0,0) leaves reset with idle sync levels, its pixel is not compared
    a_pixel_blank: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n, 3) && !active_lvl) |-> !pixel)
        else $error("frame buffer pixel is high outside the active area");

endmodule

bind video_output hack_vga_asserts #(
    .H_SYNC (128),
    .H_TOTAL(1056)
) u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .hsync     (hsync),
    .active    (active),
    .pixel     (pixel),
    .active_lvl(sync_lvl.active)
);

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 4,                  // clock period in ns
    parameter int RESET_CYCLES = 8                   // cycles with rst_n held low
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;                                // reset asserted from time 0
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;                                // release away from the rising edge
    end

    always #(PERIOD / 2) clk = ~clk;                 // free running

endmodule

`default_nettype wire

//--- rtl/hack_vga_top.sv
`timescale 1ns/100ps
`default_nettype none

module hack_vga_top import fb_pkg::*; #(
    parameter int H_ACTIVE = 800,
    parameter int H_FRONT  = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BACK   = 88,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 3,
    parameter int V_BACK   = 21
) (
    input  wire logic                 clk,            // single system clock
    input  wire logic                 rst_n,
    input  wire logic [ADDR_BITS-1:0] write_address,  // hack screen word address
    input  wire logic [WORD_BITS-1:0] data_in,        // 16 pixels to store
    input  wire logic                 load,           // store data_in this edge
    output logic                      hsync,
    output logic                      vsync,
    output logic                      active,
    output logic                      pixel_out       // 3 cycles behind the raster
);

    scan_pos_t   pos;                                 // raster position
    video_sync_t sync;                                // sync levels for pos
    logic        pixel;                               // frame buffer pixel, 2 cycles late

    sync_generator #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK)
    ) u_sync_generator (
        .clk  (clk),
        .rst_n(rst_n),
        .pos  (pos),
        .sync (sync)
    );

    frame_buffer u_frame_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .pos          (pos),
        .write_address(write_address),
        .data_in      (data_in),
        .load         (load),
        .pixel        (pixel)
    );

    video_output #(
        .PIPE_DEPTH(2)                                // address stage plus ram read
    ) u_video_output (
        .clk      (clk),
        .rst_n    (rst_n),
        .sync     (sync),
        .pixel    (pixel),
        .hsync    (hsync),
        .vsync    (vsync),
        .active   (active),
        .pixel_out(pixel_out)
    );

endmodule

`default_nettype wire

//--- rtl/video_output.sv
`timescale 1ns/100ps
`default_nettype none

module video_output import fb_pkg::*; #(
    parameter int PIPE_DEPTH = 2                     // frame buffer latency in cycles
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire video_sync_t sync,                   // levels aligned with the scan position
    input  wire logic        pixel,                  // PIPE_DEPTH cycles behind sync
    output logic             hsync,
    output logic             vsync,
    output logic             active,
    output logic             pixel_out
);

    video_sync_t sync_dly [PIPE_DEPTH];              // sync delay line
    video_sync_t sync_lvl;                           // sync level with pixel

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                sync_dly[i] <= SYNC_IDLE;
            end
        end else begin
            sync_dly[0] <= sync;
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                sync_dly[i] <= sync_dly[i-1];       // shift one stage per cycle
            end
        end
    end

    assign sync_lvl = sync_dly[PIPE_DEPTH-1];

    // final output register, no combinational path leaves the design
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync     <= 1'b1;
            vsync     <= 1'b1;
            active    <= 1'b0;
            pixel_out <= 1'b0;
        end else begin
            hsync     <= sync_lvl.hsync;
            vsync     <= sync_lvl.vsync;
            active    <= sync_lvl.active;
            pixel_out <= pixel & sync_lvl.active;    // blank outside the visible area
        end
    end

endmodule

`default_nettype wire

//--- rtl/frame_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module frame_buffer import fb_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire scan_pos_t            pos,            // raster position being scanned
    input  wire logic [ADDR_BITS-1:0] write_address,  // writer side word address
    input  wire logic [WORD_BITS-1:0] data_in,        // 16 pixels, bit 0 leftmost
    input  wire logic                 load,           // write strobe
    output logic                      pixel           // pixel of pos two cycles ago
);

    screen_addr_t         addr_next;                 // address for the current position
    screen_addr_t         addr_q;                    // stage 1 read address
    logic [IDX_BITS-1:0]  idx_next;                  // h mod 16
    logic [IDX_BITS-1:0]  idx_q1;
    logic [IDX_BITS-1:0]  idx_q2;                    // level with the ram word
    logic                 inside_next;               // position is on the hack screen
    logic                 inside_q1;
    logic                 inside_q2;
    logic [WORD_BITS-1:0] word;                      // word read from the ram

    always_comb begin
        inside_next = (pos.h < COORD_BITS'(SCREEN_W)) &&
                      (pos.v < COORD_BITS'(SCREEN_H));
        idx_next       = pos.h[IDX_BITS-1:0];
        addr_next.flat = '0;                         // border reads word 0, result is masked
        if (inside_next) begin
            addr_next.rc.row = pos.v[ROW_BITS-1:0];  // one row of words per line
            addr_next.rc.col = pos.h[IDX_BITS +: COL_BITS]; // h / 16
        end
    end

    // address and bit index pipeline
    always_ff @(posedge clk) begin
        addr_q <= addr_next;
        idx_q1 <= idx_next;
        idx_q2 <= idx_q1;                            // travels beside the ram read
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inside_q1 <= 1'b0;
            inside_q2 <= 1'b0;
        end else begin
            inside_q1 <= inside_next;
            inside_q2 <= inside_q1;
        end
    end

    vga_ram u_vga_ram (
        .clk          (clk),
        .we           (load),
        .write_address(write_address),
        .d            (data_in),
        .read_address (addr_q.flat),                 // flat view goes to the ram
        .q            (word)
    );

    assign pixel = inside_q2 & word[idx_q2];         // black outside 512 x 256

endmodule

`default_nettype wire

//--- rtl/vga_ram.sv
`timescale 1ns/100ps
`default_nettype none

module vga_ram import fb_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 we,             // write enable from the writer
    input  wire logic [ADDR_BITS-1:0] write_address,
    input  wire logic [WORD_BITS-1:0] d,              // word to store
    input  wire logic [ADDR_BITS-1:0] read_address,   // scan side address
    output logic      [WORD_BITS-1:0] q               // word read one cycle later
);

    localparam int DEPTH = 1 << ADDR_BITS;           // 8192 words

    logic [WORD_BITS-1:0] mem [DEPTH];               // screen store, block ram

    always_ff @(posedge clk) begin
        if (we) begin
            mem[write_address] <= d;                 // store on the load edge
        end
    end

    // registered read, a same-address write shows the old word
    always_ff @(posedge clk) begin
        q <= mem[read_address];
    end

endmodule

`default_nettype wire

//--- rtl/sync_generator.sv
`timescale 1ns/100ps
`default_nettype none

module sync_generator import fb_pkg::*; #(
    parameter int H_ACTIVE = 800,                   // visible columns
    parameter int H_FRONT  = 40,                    // front porch
    parameter int H_SYNC   = 128,                   // hsync pulse width
    parameter int H_BACK   = 88,                    // back porch
    parameter int V_ACTIVE = 480,                   // visible lines
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 3,
    parameter int V_BACK   = 21
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    output scan_pos_t   pos,                        // current raster position
    output video_sync_t sync                        // sync levels for pos
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;   // 1056 by default
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;   // 505 by default

    localparam int HS_START = H_ACTIVE + H_FRONT;   // first column of hsync
    localparam int HS_END   = HS_START + H_SYNC;    // first column after hsync
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int VS_END   = VS_START + V_SYNC;

    scan_pos_t   pos_next;                          // position for the next cycle
    video_sync_t sync_next;                         // sync levels of pos_next
    logic        h_wrap;                            // last column of a line
    logic        v_wrap;                            // last line of a frame

    always_comb begin
        h_wrap = (pos.h == COORD_BITS'(H_TOTAL - 1));
        v_wrap = (pos.v == COORD_BITS'(V_TOTAL - 1));

        pos_next.h = h_wrap ? '0 : pos.h + 1'b1;    // column counts every cycle
        pos_next.v = pos.v;
        if (h_wrap) begin
            pos_next.v = v_wrap ? '0 : pos.v + 1'b1; // line steps on column wrap
        end

        // levels are decoded from the next position so they land together with it
        sync_next.hsync  = !((pos_next.h >= COORD_BITS'(HS_START)) &&
                             (pos_next.h <  COORD_BITS'(HS_END)));
        sync_next.vsync  = !((pos_next.v >= COORD_BITS'(VS_START)) &&
                             (pos_next.v <  COORD_BITS'(VS_END)));
        sync_next.active = (pos_next.h < COORD_BITS'(H_ACTIVE)) &&
                           (pos_next.v < COORD_BITS'(V_ACTIVE));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos  <= '0;                             // start at top left
            sync <= SYNC_IDLE;                      // syncs high, not active
        end else begin
            pos  <= pos_next;
            sync <= sync_next;                      // aligned with pos
        end
    end

endmodule

`default_nettype wire

//--- rtl/fb_pkg.sv
`default_nettype none

package fb_pkg;

    localparam int SCREEN_W   = 512;                          // hack screen width in pixels
    localparam int SCREEN_H   = 256;                          // hack screen height in lines
    localparam int WORD_BITS  = 16;                           // pixels per ram word
    localparam int ADDR_BITS  = 13;                           // 8192 words of screen
    localparam int COORD_BITS = 11;                           // enough for 1056 columns

    localparam int IDX_BITS = $clog2(WORD_BITS);              // pixel index inside a word
    localparam int COL_BITS = $clog2(SCREEN_W / WORD_BITS);   // 32 words per row
    localparam int ROW_BITS = $clog2(SCREEN_H);               // 256 rows

    typedef struct packed {
        logic [COORD_BITS-1:0] h;                             // raster column
        logic [COORD_BITS-1:0] v;                             // raster line
    } scan_pos_t;

    typedef struct packed {
        logic hsync;                                          // active low
        logic vsync;                                          // active low
        logic active;                                         // visible area flag
    } video_sync_t;

    // sync levels while idle or in reset
    localparam video_sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};

    typedef struct packed {
        logic [ROW_BITS-1:0] row;                             // screen line, upper address bits
        logic [COL_BITS-1:0] col;                             // word within the line
    } screen_rc_t;

    // one screen address, seen either as row/col or as the flat ram index
    typedef union packed {
        logic [ADDR_BITS-1:0] flat;                           // row*32 + col
        screen_rc_t           rc;
    } screen_addr_t;

endpackage

`default_nettype wire
